//--- logic/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// datapath width
`define RV_XLEN         32

// x0..x31
`define RV_NREGS        32

// pc step, one instruction
`define RV_INSTR_LEN    4

// first fetch address
`define RV_RESET_VECTOR 32'h0000_0000

// byte cycles per word access on the 8-bit bus
`define RV_BUS_BYTES    4

`endif

//--- logic/rv_pkg.sv
`default_nettype none

`include "rv_config.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [$clog2(`RV_NREGS)-1:0] reg_idx_t;
    typedef logic [$clog2(`RV_BUS_BYTES)-1:0] byte_idx_t;

    // major opcodes, instr[6:2]
    typedef enum logic [4:0] {
        OPC_LOAD    = 5'b00000,
        OPC_MISCMEM = 5'b00011,
        OPC_OPIMM   = 5'b00100,
        OPC_AUIPC   = 5'b00101,
        OPC_STORE   = 5'b01000,
        OPC_OP      = 5'b01100,
        OPC_LUI     = 5'b01101,
        OPC_BRANCH  = 5'b11000,
        OPC_JALR    = 5'b11001,
        OPC_JAL     = 5'b11011,
        OPC_SYSTEM  = 5'b11100
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_t;

    typedef struct packed {
        opcode_t      opcode;
        reg_idx_t     rs1;
        reg_idx_t     rs2;
        reg_idx_t     rd;
        logic [2:0]   funct3;
        logic         funct7_b5;  // sub / sra select
        word_t        imm;        // sign-extended, format per opcode
        logic [6:0]   funct7;
        logic [11:0]  funct12;
        logic [4:0]   shamt;
    } decoded_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
    } bus_req_t;

    typedef enum logic [3:0] {
        ST_RESET, ST_FETCH, ST_DECODE, ST_REGREAD, ST_EXEC, ST_MEMADDR,
        ST_MEMACCESS, ST_WRITEBACK, ST_BRANCH, ST_LINK, ST_PCNEXT, ST_PCUPDATE
    } ctrl_state_t;

    typedef enum logic [1:0] {
        BUS_IDLE, BUS_STROBE, BUS_GAP
    } bus_state_t;

endpackage

`default_nettype wire

//--- logic/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder
    import rv_pkg::*;
(
    input  wire word_t instr,
    output decoded_t   dec
);

    always_comb begin
        dec.rs1       = instr[19:15];
        dec.rs2       = instr[24:20];
        dec.rd        = instr[11:7];
        dec.funct3    = instr[14:12];
        dec.funct7_b5 = instr[30];
        dec.funct7    = instr[31:25];
        dec.funct12   = instr[31:20];
        dec.shamt     = instr[24:20];

        case (instr[6:2])
            OPC_LOAD, OPC_MISCMEM, OPC_OPIMM, OPC_AUIPC, OPC_STORE, OPC_OP,
            OPC_LUI, OPC_BRANCH, OPC_JALR, OPC_JAL, OPC_SYSTEM:
                dec.opcode = opcode_t'(instr[6:2]);
            default:
                dec.opcode = OPC_MISCMEM;  // unknown acts as nop
        endcase
        if (instr[1:0] != 2'b11)
            dec.opcode = OPC_MISCMEM;      // not a 32-bit encoding

        case (dec.opcode)
            OPC_STORE:
                dec.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            OPC_BRANCH:
                dec.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                           instr[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC:
                dec.imm = {instr[31:12], 12'b0};
            OPC_JAL:
                dec.imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                           instr[30:21], 1'b0};
            default:
                dec.imm = {{20{instr[31]}}, instr[31:20]};  // I-type
        endcase
    end

endmodule

`default_nettype wire

//--- logic/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu
    import rv_pkg::*;
(
    input  wire alu_op_t op,
    input  wire word_t   a,
    input  wire word_t   b,
    output word_t        result,
    output logic         eq,
    output logic         lt,
    output logic         ltu
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    // flags always valid, branches read them directly
    assign eq  = (a == b);
    assign lt  = ($signed(a) < $signed(b));
    assign ltu = (a < b);

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = word_t'(lt);
            ALU_SLTU: result = word_t'(ltu);
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = word_t'($signed(a) >>> shamt);
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = a + b;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module rv_regfile
    import rv_pkg::*;
(
    input  wire           clk,
    input  wire           reset,
    input  wire decoded_t dec,
    input  wire           we,
    input  wire reg_idx_t rd,
    input  wire word_t    wdata,
    output word_t         rs1_val,
    output word_t         rs2_val
);

    word_t regs [`RV_NREGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RV_NREGS; i++)
                regs[i] <= '0;
        end else if (we && rd != '0) begin  // x0 never written
            regs[rd] <= wdata;
        end
    end

    assign rs1_val = regs[dec.rs1];
    assign rs2_val = regs[dec.rs2];

endmodule

`default_nettype wire

//--- logic/rv_bus_wb8.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module rv_bus_wb8
    import rv_pkg::*;
(
    input  wire           clk,
    input  wire           reset,
    input  wire           start,
    input  wire bus_req_t req,
    output logic          done,
    output word_t         rdata,
    output word_t         wb_adr,
    output logic [7:0]    wb_wdata,
    input  wire  [7:0]    wb_rdata,
    output logic          wb_cyc,
    output logic          wb_stb,
    output logic          wb_we,
    input  wire           wb_ack
);

    bus_state_t state;
    byte_idx_t  byte_cnt;
    bus_req_t   req_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= BUS_IDLE;
            byte_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                BUS_IDLE: if (start) begin
                    state    <= BUS_STROBE;
                    byte_cnt <= '0;
                end
                BUS_STROBE: if (wb_ack) begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == byte_idx_t'(`RV_BUS_BYTES - 1)) begin
                        state <= BUS_IDLE;
                        done  <= 1'b1;  // one cycle after last ack
                    end else begin
                        state <= BUS_GAP;
                    end
                end
                BUS_GAP: state <= BUS_STROBE;
                default: state <= BUS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == BUS_IDLE && start)
            req_q <= req;
        if (state == BUS_STROBE && wb_ack && !req_q.we)
            rdata <= {wb_rdata, rdata[`RV_XLEN-1:8]};  // lsb arrives first
    end

    assign wb_cyc   = (state == BUS_STROBE);
    assign wb_stb   = (state == BUS_STROBE);
    assign wb_we    = wb_cyc && req_q.we;
    assign wb_adr   = {req_q.addr[`RV_XLEN-1:2], byte_cnt};  // word aligned
    assign wb_wdata = req_q.wdata[{byte_cnt, 3'b000} +: 8];

endmodule

`default_nettype wire

//--- logic/rv_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module rv_control
    import rv_pkg::*;
(
    input  wire           clk,
    input  wire           reset,
    input  wire decoded_t dec,
    output word_t         instr,
    input  wire word_t    rs1_val,
    input  wire word_t    rs2_val,
    output alu_op_t       alu_op,
    output word_t         alu_a,
    output word_t         alu_b,
    input  wire word_t    alu_result,
    input  wire           alu_eq,
    input  wire           alu_lt,
    input  wire           alu_ltu,
    output logic          reg_we,
    output reg_idx_t      rd,
    output word_t         reg_wdata,
    output logic          bus_start,
    output bus_req_t      bus_req,
    input  wire           bus_done,
    input  wire word_t    bus_rdata
);

    ctrl_state_t state;
    word_t       pc;
    word_t       npc_q;     // next pc, settled in PCNEXT
    word_t       result_q;  // alu result or link value
    logic        taken_q;
    alu_op_t     func_op;
    logic        branch_take;
    logic        is_jump;
    logic        writes_rd;

    assign is_jump   = (dec.opcode == OPC_JAL) || (dec.opcode == OPC_JALR);
    assign writes_rd = is_jump || dec.opcode inside {OPC_OP, OPC_OPIMM, OPC_LUI,
                                                     OPC_AUIPC, OPC_LOAD};

    always_comb begin
        case (dec.funct3)
            3'b000:  func_op = (dec.opcode == OPC_OP && dec.funct7_b5) ? ALU_SUB : ALU_ADD;
            3'b001:  func_op = ALU_SLL;
            3'b010:  func_op = ALU_SLT;
            3'b011:  func_op = ALU_SLTU;
            3'b100:  func_op = ALU_XOR;
            3'b101:  func_op = dec.funct7_b5 ? ALU_SRA : ALU_SRL;
            3'b110:  func_op = ALU_OR;
            default: func_op = ALU_AND;
        endcase
    end

    always_comb begin
        case (dec.funct3)
            3'b000:  branch_take = alu_eq;
            3'b001:  branch_take = !alu_eq;
            3'b100:  branch_take = alu_lt;
            3'b101:  branch_take = !alu_lt;
            3'b110:  branch_take = alu_ltu;
            3'b111:  branch_take = !alu_ltu;
            default: branch_take = 1'b0;
        endcase
    end

    // operand select, rs1/rs2 unless the state says otherwise
    always_comb begin
        alu_a  = rs1_val;
        alu_b  = rs2_val;
        alu_op = ALU_ADD;
        case (state)
            ST_EXEC: begin
                if (dec.opcode == OPC_AUIPC)
                    alu_a = pc;
                else
                    alu_op = func_op;
                if (dec.opcode != OPC_OP)
                    alu_b = dec.imm;
            end
            ST_MEMADDR: alu_b = dec.imm;
            ST_LINK: begin
                alu_a = pc;
                alu_b = word_t'(`RV_INSTR_LEN);
            end
            ST_PCNEXT: begin
                if (dec.opcode != OPC_JALR)
                    alu_a = pc;
                alu_b = (is_jump || taken_q) ? dec.imm : word_t'(`RV_INSTR_LEN);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= ST_RESET;
            pc      <= `RV_RESET_VECTOR;
            taken_q <= 1'b0;
        end else begin
            case (state)
                ST_RESET:     state <= ST_FETCH;
                ST_FETCH:     state <= ST_DECODE;
                ST_DECODE:    if (bus_done) state <= ST_REGREAD;
                ST_REGREAD: begin
                    taken_q <= 1'b0;
                    case (dec.opcode)
                        OPC_OP, OPC_OPIMM, OPC_AUIPC: state <= ST_EXEC;
                        OPC_LOAD, OPC_STORE:          state <= ST_MEMADDR;
                        OPC_JAL, OPC_JALR:            state <= ST_LINK;
                        OPC_BRANCH:                   state <= ST_BRANCH;
                        default:                      state <= ST_PCNEXT;
                    endcase
                end
                ST_EXEC:      state <= ST_PCNEXT;
                ST_MEMADDR:   state <= ST_MEMACCESS;
                ST_MEMACCESS: if (bus_done) state <= ST_PCNEXT;
                ST_BRANCH: begin
                    taken_q <= branch_take;
                    state   <= ST_PCNEXT;
                end
                ST_LINK:      state <= ST_PCNEXT;
                // target settles before rd is written, so jalr rd == rs1 is safe
                ST_PCNEXT:    state <= writes_rd ? ST_WRITEBACK : ST_PCUPDATE;
                ST_WRITEBACK: state <= ST_PCUPDATE;
                ST_PCUPDATE: begin
                    pc    <= npc_q;
                    state <= ST_DECODE;  // fetch already started
                end
                default:      state <= ST_RESET;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_DECODE && bus_done)
            instr <= bus_rdata;
        if (state == ST_EXEC || state == ST_LINK)
            result_q <= alu_result;
        if (state == ST_PCNEXT)
            npc_q <= {alu_result[`RV_XLEN-1:1], 1'b0};
    end

    always_comb begin
        case (dec.opcode)
            OPC_LOAD: reg_wdata = bus_rdata;
            OPC_LUI:  reg_wdata = dec.imm;
            default:  reg_wdata = result_q;
        endcase
    end

    assign reg_we = (state == ST_WRITEBACK);
    assign rd     = dec.rd;

    assign bus_start = (state == ST_FETCH) || (state == ST_MEMADDR)
                    || (state == ST_PCUPDATE);

    always_comb begin
        bus_req.wdata = rs2_val;
        bus_req.we    = 1'b0;
        case (state)
            ST_MEMADDR: begin
                bus_req.addr = alu_result;
                bus_req.we   = (dec.opcode == OPC_STORE);
            end
            ST_PCUPDATE: bus_req.addr = npc_q;
            default:     bus_req.addr = pc;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core
    import rv_pkg::*;
(
    input  wire         clk,
    input  wire         reset,
    output word_t       wb_adr,
    output logic [7:0]  wb_wdata,
    input  wire  [7:0]  wb_rdata,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic        wb_we,
    input  wire         wb_ack
);

    word_t    instr, rs1_val, rs2_val, alu_a, alu_b, alu_result, reg_wdata, bus_rdata;
    decoded_t dec;
    alu_op_t  alu_op;
    logic     alu_eq, alu_lt, alu_ltu, reg_we, bus_start, bus_done;
    reg_idx_t rd;
    bus_req_t bus_req;

    rv_control control_i (
        .clk, .reset, .dec, .instr, .rs1_val, .rs2_val, .alu_op, .alu_a, .alu_b,
        .alu_result, .alu_eq, .alu_lt, .alu_ltu, .reg_we, .rd, .reg_wdata,
        .bus_start, .bus_req, .bus_done, .bus_rdata
    );

    rv_decoder decoder_i (.instr, .dec);

    rv_regfile regfile_i (
        .clk, .reset, .dec, .we(reg_we), .rd, .wdata(reg_wdata), .rs1_val, .rs2_val
    );

    rv_alu alu_i (
        .op(alu_op), .a(alu_a), .b(alu_b), .result(alu_result),
        .eq(alu_eq), .lt(alu_lt), .ltu(alu_ltu)
    );

    rv_bus_wb8 bus_i (
        .clk, .reset, .start(bus_start), .req(bus_req), .done(bus_done),
        .rdata(bus_rdata), .wb_adr, .wb_wdata, .wb_rdata, .wb_cyc, .wb_stb, .wb_we, .wb_ack
    );

endmodule

`default_nettype wire

//--- sim/rv_core_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_asserts
    import rv_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire        wb_cyc,
    input  wire        wb_stb,
    input  wire        wb_ack,
    input  wire word_t wb_adr,
    input  wire [7:0]  wb_wdata
);

    // one idle cycle between byte cycles
    gap_after_ack: assert property (@(posedge clk) disable iff (reset)
        wb_stb && wb_ack |=> !wb_stb && !wb_cyc)
        else $error("wb_cyc or wb_stb still high in the cycle after ack");

    // a waiting strobe keeps its address and data
    stb_held: assert property (@(posedge clk) disable iff (reset)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_wdata))
        else $error("wb_stb dropped or address/data changed before ack");

    cyc_low_in_reset: assert property (@(posedge clk) reset && $past(reset) |-> !wb_cyc)
        else $error("wb_cyc high during reset");

endmodule

bind rv_bus_wb8 rv_core_asserts asserts_i (.*);

`default_nettype wire

//--- sim/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module rv_core_tb
    import rv_pkg::*;
();

    localparam logic [6:0] C_LOAD = 7'b0000011, C_OPIMM = 7'b0010011, C_AUIPC = 7'b0010111;
    localparam logic [6:0] C_LUI = 7'b0110111, C_JALR = 7'b1100111;
    localparam int SLOT_BASE = 'h200;
    localparam int MARK_ADDR = 'h3fc;
    localparam int MARK_VAL = 'h5a5;
    localparam int TOTAL_INSTR = 210;             // all programs together rounded up
    localparam int CYCLE_LIMIT = TOTAL_INSTR * 120;
    localparam word_t A = 32'hffff_fff9;          // -7
    localparam word_t B = 32'd100;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        wb_ack = 1'b0;
    logic [7:0]  wb_rdata = 8'h00;
    word_t       wb_adr;
    logic [7:0]  wb_wdata;
    logic        wb_cyc, wb_stb, wb_we;

    logic [7:0]  mem [1024];
    word_t       lfsr = 32'hb034;
    logic [1:0]  ack_wait = 2'd0;
    logic        ack_active = 1'b0;
    logic        marker_seen = 1'b0;
    logic        rnd_lo, rnd_hi;
    int          cycles = 0;
    word_t       prog [$];
    word_t       exp_q [$];

    rv_core rv_core_i (.*);

    always #5 clk = ~clk;

    function automatic word_t lfsr_step(word_t s);
        return (s >> 1) ^ (s[0] ? 32'ha300_0000 : 32'h0);
    endfunction

    function automatic logic [7:0] fill_byte(int a);
        return 8'(a) ^ 8'(a >> 8) ^ 8'h5c;
    endfunction

    function automatic word_t read_word(int a);
        return {mem[a + 3], mem[a + 2], mem[a + 1], mem[a]};
    endfunction

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_word(string name, word_t got, word_t expected);
        if (got !== expected)
            abort_run($sformatf("MISMATCH at %0t: %s got %h expected %h",
                                $time, name, got, expected));
    endtask

    task automatic check_addr(word_t got, word_t expected);
        if (got !== expected)
            abort_run($sformatf("MISMATCH at %0t: wb_adr got %h expected %h",
                                $time, got, expected));
    endtask

    // byte slave acking after a random wait of 0..3 cycles
    always @(posedge clk) begin
        wb_ack <= 1'b0;
        if (reset) begin
            ack_active  <= 1'b0;
            marker_seen <= 1'b0;
        end else if (wb_cyc && wb_stb && !wb_ack) begin
            if (wb_adr[31:10] != '0)
                abort_run($sformatf("bus address %h is outside the memory", wb_adr));
            if (!ack_active) begin
                rnd_lo = lfsr[0];
                lfsr = lfsr_step(lfsr);
                rnd_hi = lfsr[0];
                lfsr = lfsr_step(lfsr);
                ack_wait   <= {rnd_hi, rnd_lo};
                ack_active <= 1'b1;
            end else if (ack_wait == 2'd0) begin
                wb_ack     <= 1'b1;
                ack_active <= 1'b0;
                if (wb_we) begin
                    mem[wb_adr[9:0]] = wb_wdata;
                    if (wb_adr[9:0] == 10'(MARK_ADDR + 3))
                        marker_seen <= 1'b1;  // last byte of the marker
                end else begin
                    wb_rdata <= mem[wb_adr[9:0]];
                end
            end else begin
                ack_wait <= ack_wait - 2'd1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
            abort_run($sformatf("timeout after %0d cycles, marker store never seen", cycles));
    end

    function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t enc_i(word_t imm, reg_idx_t rs1, logic [2:0] f3,
                                    reg_idx_t rd, logic [6:0] opc);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(word_t imm, reg_idx_t rs2, reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t enc_b(word_t imm, reg_idx_t rs2, reg_idx_t rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t enc_u(logic [19:0] imm, reg_idx_t rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t enc_j(word_t imm, reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic word_t pc_now();
        return `RV_RESET_VECTOR + word_t'(prog.size() * 4);
    endfunction

    // RV32I branch conditions by funct3
    function automatic logic branch_rule(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic store_slot(word_t expected);
        prog.push_back(enc_s(word_t'(SLOT_BASE + 4 * exp_q.size()), 10, 0));
        exp_q.push_back(expected);
    endtask

    task automatic op_store(word_t instr, word_t expected);
        prog.push_back(instr);
        store_slot(expected);
    endtask

    task automatic load_program();
        for (int a = 0; a < 1024; a++)
            mem[a] = fill_byte(a);
        foreach (prog[i])
            {mem[4*i + 3], mem[4*i + 2], mem[4*i + 1], mem[4*i]} = prog[i];
    endtask

    task automatic run_program(string name);
        prog.push_back(enc_i(MARK_VAL, 0, 3'b000, 31, C_OPIMM));
        prog.push_back(enc_s(MARK_ADDR, 31, 0));
        prog.push_back(enc_j(0, 0));  // park in place
        @(posedge clk);
        reset <= 1'b1;
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            if (i == 7)
                reset <= 1'b0;
            @(negedge clk);
            if (wb_cyc !== 1'b0)
                abort_run({name, ": wb_cyc went high while reset was held"});
            if (i == 2)
                load_program();
        end
        do @(negedge clk); while (wb_cyc !== 1'b1);
        check_addr(wb_adr, `RV_RESET_VECTOR);
        if (wb_we !== 1'b0)
            abort_run({name, ": first bus cycle after reset is a write"});
        while (!marker_seen)
            @(negedge clk);
        check_word({name, " marker"}, read_word(MARK_ADDR), MARK_VAL);
        foreach (exp_q[i])
            check_word($sformatf("%s mem[%h]", name, SLOT_BASE + 4*i),
                       read_word(SLOT_BASE + 4*i), exp_q[i]);
        prog.delete();
        exp_q.delete();
    endtask

    task automatic test_alu();
        prog.push_back(enc_i(-7, 0, 3'b000, 1, C_OPIMM));
        prog.push_back(enc_i(100, 0, 3'b000, 2, C_OPIMM));
        prog.push_back(enc_i(3, 0, 3'b000, 6, C_OPIMM));
        op_store(enc_r(7'h00, 2, 1, 3'b000, 10), A + B);
        op_store(enc_r(7'h20, 2, 1, 3'b000, 10), A - B);
        op_store(enc_r(7'h00, 6, 2, 3'b001, 10), B << 3);
        op_store(enc_r(7'h00, 6, 1, 3'b101, 10), A >> 3);
        op_store(enc_r(7'h20, 6, 1, 3'b101, 10), word_t'($signed(A) >>> 3));
        op_store(enc_r(7'h00, 2, 1, 3'b010, 10), word_t'($signed(A) < $signed(B)));
        op_store(enc_r(7'h00, 2, 1, 3'b011, 10), word_t'(A < B));
        op_store(enc_r(7'h00, 2, 1, 3'b100, 10), A ^ B);
        op_store(enc_r(7'h00, 2, 1, 3'b110, 10), A | B);
        op_store(enc_r(7'h00, 2, 1, 3'b111, 10), A & B);
        op_store(enc_i(4, 1, 3'b001, 10, C_OPIMM), A << 4);
        op_store(enc_i(28, 1, 3'b101, 10, C_OPIMM), A >> 28);
        op_store(enc_i(32'h402, 1, 3'b101, 10, C_OPIMM), word_t'($signed(A) >>> 2));
        op_store(enc_i(-3, 1, 3'b010, 10, C_OPIMM), word_t'($signed(A) < -3));
        op_store(enc_i(-1, 2, 3'b011, 10, C_OPIMM), word_t'(B < 32'hffff_ffff));
        op_store(enc_i(-1, 1, 3'b100, 10, C_OPIMM), ~A);
        op_store(enc_i(32'h0f0, 1, 3'b110, 10, C_OPIMM), A | 32'h0f0);
        op_store(enc_i(32'h0f0, 1, 3'b111, 10, C_OPIMM), A & 32'h0f0);
        run_program("alu");
    endtask

    task automatic test_upper_mem();
        word_t p;
        prog.push_back(enc_i(-7, 0, 3'b000, 1, C_OPIMM));
        op_store(enc_u(20'h12345, 10, C_LUI), 32'h1234_5000);
        p = pc_now();
        op_store(enc_u(20'h00001, 10, C_AUIPC), p + 32'h1000);
        prog.push_back(enc_s('h380, 1, 0));
        op_store(enc_i('h380, 0, 3'b010, 10, C_LOAD), A);
        op_store(enc_i('h380, 0, 3'b000, 10, C_LOAD), A);  // byte funct3 still moves a word
        op_store(enc_i('h3c0, 0, 3'b010, 10, C_LOAD), read_word_fill('h3c0));
        prog.push_back(enc_i(5, 0, 3'b000, 0, C_OPIMM));   // write to x0
        op_store(enc_r(7'h00, 0, 0, 3'b000, 10), 32'h0);
        run_program("upper_mem");
    endtask

    function automatic word_t read_word_fill(int a);
        return {fill_byte(a + 3), fill_byte(a + 2), fill_byte(a + 1), fill_byte(a)};
    endfunction

    task automatic branch_case(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2, word_t a, word_t b);
        prog.push_back(enc_i(1, 0, 3'b000, 10, C_OPIMM));
        prog.push_back(enc_b(8, rs2, rs1, f3));
        op_store(enc_i(2, 0, 3'b000, 10, C_OPIMM), branch_rule(f3, a, b) ? 32'd1 : 32'd2);
    endtask

    task automatic test_branches();
        logic [2:0] f3s [6];
        word_t p;
        f3s = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        prog.push_back(enc_i(-7, 0, 3'b000, 1, C_OPIMM));
        prog.push_back(enc_i(100, 0, 3'b000, 2, C_OPIMM));
        prog.push_back(enc_i(100, 0, 3'b000, 3, C_OPIMM));
        prog.push_back(enc_i(3, 0, 3'b000, 6, C_OPIMM));
        foreach (f3s[i]) begin
            branch_case(f3s[i], 1, 2, A, B);
            branch_case(f3s[i], 2, 1, B, A);
            branch_case(f3s[i], 2, 3, B, B);
        end
        prog.push_back(enc_i(0, 0, 3'b000, 5, C_OPIMM));
        prog.push_back(enc_i(1, 5, 3'b000, 5, C_OPIMM));
        prog.push_back(enc_b(-4, 6, 5, 3'b001));          // count up to 3 backwards
        op_store(enc_i(0, 5, 3'b000, 10, C_OPIMM), 32'd3);
        p = pc_now();
        prog.push_back(enc_j(8, 10));
        op_store(enc_i(99, 0, 3'b000, 10, C_OPIMM), p + 4);
        p = pc_now();
        prog.push_back(enc_u(20'h0, 12, C_AUIPC));
        prog.push_back(enc_i(12, 12, 3'b000, 10, C_JALR));
        op_store(enc_i(99, 0, 3'b000, 10, C_OPIMM), p + 8);
        p = pc_now();
        prog.push_back(enc_u(20'h0, 10, C_AUIPC));
        prog.push_back(enc_i(12, 10, 3'b000, 10, C_JALR)); // rd == rs1
        op_store(enc_i(99, 0, 3'b000, 10, C_OPIMM), p + 8);
        run_program("branches");
    endtask

    task automatic test_nop();
        prog.push_back(enc_i(42, 0, 3'b000, 10, C_OPIMM));
        prog.push_back(32'h0000_057b);  // unknown opcode with rd field x10
        prog.push_back(32'h0000_0000);  // not a 32-bit encoding
        prog.push_back(32'h0ff0_000f);  // fence
        store_slot(32'd42);
        run_program("nop");
    endtask

    initial begin
        test_alu();
        test_alu();     // same program under other ack delays
        test_upper_mem();
        test_branches();
        test_nop();
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+logic
logic/rv_pkg.sv
logic/rv_decoder.sv
logic/rv_alu.sv
logic/rv_regfile.sv
logic/rv_bus_wb8.sv
logic/rv_control.sv
logic/rv_core.sv
sim/rv_core_asserts.sv
sim/rv_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing

SOURCES := $(FILELIST) $(wildcard logic/*.sv logic/*.svh sim/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
